// File: vlog.f
logic/muldiv_pkg.sv
logic/div_ctrl_if.sv
logic/div_dpath.sv
logic/div_ctrl.sv
logic/mul_iterative.sv
logic/muldiv_iterative.sv
verif/muldiv_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the mul/div testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module muldiv_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/Vmuldiv_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: verif/muldiv_tb.sv
// testbench for the iterative multiply/divide unit
// random and corner-case requests, checked against a reference model

`timescale 1ns/100ps

module muldiv_tb;

  logic                          clk;
  logic                          reset;
  logic                          req_val;
  muldiv_pkg::muldiv_fn_e        req_fn;
  logic [muldiv_pkg::XLEN-1:0]   req_a;
  logic [muldiv_pkg::XLEN-1:0]   req_b;
  logic                          req_rdy;
  logic                          resp_val;
  logic [2*muldiv_pkg::XLEN-1:0] resp_result;
  logic                          resp_rdy;

  // expected results in request order
  logic [2*muldiv_pkg::XLEN-1:0] exp_q[$];
  logic [2*muldiv_pkg::XLEN-1:0] exp_val;
  int                            issued;
  int                            taken;
  int                            cycles;

  muldiv_iterative i_muldiv_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_result (resp_result),
    .resp_rdy    (resp_rdy)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ------------------------------------------------------------
  // reporting and compare tasks
  // ------------------------------------------------------------

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input logic [2*muldiv_pkg::XLEN-1:0] exp,
                              input logic [2*muldiv_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
      fail_run();
    end
  endtask

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  function automatic logic [2*muldiv_pkg::XLEN-1:0] ref_result(
      input muldiv_pkg::muldiv_fn_e fn,
      input logic [muldiv_pkg::XLEN-1:0] a,
      input logic [muldiv_pkg::XLEN-1:0] b);
    logic                          sgn;
    logic [muldiv_pkg::XLEN-1:0]   ma;
    logic [muldiv_pkg::XLEN-1:0]   mb;
    logic [muldiv_pkg::XLEN-1:0]   q;
    logic [muldiv_pkg::XLEN-1:0]   r;
    logic [2*muldiv_pkg::XLEN-1:0] p;
    sgn = (fn == muldiv_pkg::MUL) || (fn == muldiv_pkg::DIV);
    ma  = (sgn && a[muldiv_pkg::XLEN-1]) ? -a : a;
    mb  = (sgn && b[muldiv_pkg::XLEN-1]) ? -b : b;
    if (fn == muldiv_pkg::MUL || fn == muldiv_pkg::MULU) begin
      p = {{muldiv_pkg::XLEN{1'b0}}, ma} * {{muldiv_pkg::XLEN{1'b0}}, mb};
      // product negative when the signs differ
      if (sgn && (a[muldiv_pkg::XLEN-1] ^ b[muldiv_pkg::XLEN-1])) p = -p;
      return p;
    end
    // divide by zero: all-ones quotient, remainder is the dividend
    if (mb == '0) begin
      q = '1;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    if (sgn && (a[muldiv_pkg::XLEN-1] ^ b[muldiv_pkg::XLEN-1])) q = -q;
    // remainder follows the dividend
    if (sgn && a[muldiv_pkg::XLEN-1]) r = -r;
    return {r, q};
  endfunction

  // mix of corner values and plain random words
  function automatic logic [muldiv_pkg::XLEN-1:0] pick_operand();
    case ($urandom_range(0, 7))
      0: return '0;
      1: return 32'h8000_0000;
      2: return 32'hffff_ffff;
      3: return 32'h7fff_ffff;
      4: return 32'h0000_0001;
      default: return $urandom;
    endcase
  endfunction

  // ------------------------------------------------------------
  // one request/response round trip
  // ------------------------------------------------------------

  task automatic run_op(input muldiv_pkg::muldiv_fn_e fn, input logic [muldiv_pkg::XLEN-1:0] a,
                        input logic [muldiv_pkg::XLEN-1:0] b);
    int                            lat;
    int                            stall;
    logic [2*muldiv_pkg::XLEN-1:0] held;
    @(negedge clk);
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    exp_q.push_back(ref_result(fn, a, b));
    issued++;
    // request held until the accepting edge
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    @(negedge clk);
    req_val = 1'b0;
    // count edges until resp_val is seen high
    lat = 1;
    @(posedge clk);
    while (!resp_val) begin
      lat++;
      @(posedge clk);
    end
    check_latency("resp_val latency", 33, lat);
    // back-pressure, response must hold
    held  = resp_result;
    stall = $urandom_range(0, 7);
    repeat (stall) begin
      @(posedge clk);
      check_flag("resp_val", 1'b1, resp_val);
      check_flag("req_rdy", 1'b0, req_rdy);
      check_result("resp_result", held, resp_result);
    end
    @(negedge clk);
    resp_rdy = 1'b1;
    @(negedge clk);
    resp_rdy = 1'b0;
  endtask

  // ------------------------------------------------------------
  // response checker and timeout
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("response taken at %0t with no request outstanding", $time);
        fail_run();
      end else begin
        exp_val = exp_q.pop_front();
        check_result("resp_result", exp_val, resp_result);
        taken++;
      end
    end
  end

  // 200 ops of about 45 cycles each, with margin
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 12000) begin
      $display("timeout: the run did not finish within 12000 cycles");
      fail_run();
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  initial begin
    void'($urandom(13957));
    clk      = 1'b0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = muldiv_pkg::MUL;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    issued   = 0;
    taken    = 0;
    cycles   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // idle after reset
    repeat (2) begin
      @(posedge clk);
      check_flag("req_rdy", 1'b1, req_rdy);
      check_flag("resp_val", 1'b0, resp_val);
    end
    // signed overflow case and divide by zero
    run_op(muldiv_pkg::DIV, 32'h8000_0000, 32'hffff_ffff);
    run_op(muldiv_pkg::DIV, 32'h0000_1234, 32'h0000_0000);
    run_op(muldiv_pkg::DIV, 32'hffff_fff9, 32'h0000_0000);
    run_op(muldiv_pkg::DIVU, 32'hdead_beef, 32'h0000_0000);
    run_op(muldiv_pkg::DIVU, 32'h0000_0000, 32'h0000_0000);
    run_op(muldiv_pkg::MUL, 32'h8000_0000, 32'h8000_0000);
    run_op(muldiv_pkg::MUL, 32'hffff_ffff, 32'h7fff_ffff);
    run_op(muldiv_pkg::MULU, 32'hffff_ffff, 32'hffff_ffff);
    repeat (192) begin
      run_op(muldiv_pkg::muldiv_fn_e'($urandom_range(0, 3)), pick_operand(), pick_operand());
    end
    @(posedge clk);
    if (taken != issued) begin
      $display("only %0d of %0d responses were taken", taken, issued);
      fail_run();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: logic/muldiv_iterative.sv
// iterative multiply/divide unit, top level
// steers each request by function class and merges the two units' responses

`timescale 1ns/100ps

module muldiv_iterative (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  input  muldiv_pkg::muldiv_fn_e        req_fn,
  input  logic [muldiv_pkg::XLEN-1:0]   req_a,
  input  logic [muldiv_pkg::XLEN-1:0]   req_b,
  output logic                          req_rdy,
  output logic                          resp_val,
  output logic [2*muldiv_pkg::XLEN-1:0] resp_result,
  input  logic                          resp_rdy
);

  logic is_div;
  logic mul_req_val;
  logic div_req_val;
  logic mul_req_rdy;
  logic div_req_rdy;
  logic mul_resp_val;
  logic div_resp_val;

  logic [2*muldiv_pkg::XLEN-1:0] mul_result;
  logic [2*muldiv_pkg::XLEN-1:0] div_result;

  // DIV/DIVU to the divider, MUL/MULU to the multiplier
  assign is_div      = (req_fn == muldiv_pkg::DIV) || (req_fn == muldiv_pkg::DIVU);
  // a unit only sees a request the top level is ready to take
  assign mul_req_val = req_val && req_rdy && !is_div;
  assign div_req_val = req_val && req_rdy && is_div;

  // one operation in flight, so both units must be idle
  assign req_rdy = mul_req_rdy && div_req_rdy;

  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp_result = div_resp_val ? div_result : mul_result;

  // ------------------------------------------------------------
  // multiplier
  // ------------------------------------------------------------

  mul_iterative i_mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_fn   (req_fn),
    .req_a    (req_a),
    .req_b    (req_b),
    .resp_rdy (resp_rdy),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .result   (mul_result)
  );

  // ------------------------------------------------------------
  // divider, control FSM plus datapath
  // ------------------------------------------------------------

  div_ctrl_if div_if ();

  div_ctrl i_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_fn   (req_fn),
    .resp_rdy (resp_rdy),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .ctrl_if  (div_if.ctrl)
  );

  div_dpath i_div_dpath (
    .clk     (clk),
    .reset   (reset),
    .ctrl_if (div_if.dpath),
    .req_a   (req_a),
    .req_b   (req_b),
    .result  (div_result)
  );

  // the merge above relies on this
  a_one_valid: assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val));

endmodule

// File: logic/mul_iterative.sv
// iterative multiplier
// shift-and-add over 32 cycles on magnitudes, product sign applied at the output

`timescale 1ns/100ps

module mul_iterative (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  input  muldiv_pkg::muldiv_fn_e        req_fn,
  input  logic [muldiv_pkg::XLEN-1:0]   req_a,
  input  logic [muldiv_pkg::XLEN-1:0]   req_b,
  input  logic                          resp_rdy,
  output logic                          req_rdy,
  output logic                          resp_val,
  output logic [2*muldiv_pkg::XLEN-1:0] result
);

  muldiv_pkg::unit_state_e state;

  logic [2*muldiv_pkg::XLEN-1:0] mcand;
  logic [muldiv_pkg::XLEN-1:0]   mplier;
  logic [2*muldiv_pkg::XLEN-1:0] acc;
  logic [muldiv_pkg::CNT_W-1:0]  cnt;
  logic                          neg;

  logic                        is_signed;
  logic [muldiv_pkg::XLEN-1:0] mag_a;
  logic [muldiv_pkg::XLEN-1:0] mag_b;
  logic                        accept;
  logic                        send;

  assign is_signed = (req_fn == muldiv_pkg::MUL);

  // magnitudes only for the signed multiply
  assign mag_a = (is_signed && req_a[muldiv_pkg::XLEN-1]) ? -req_a : req_a;
  assign mag_b = (is_signed && req_b[muldiv_pkg::XLEN-1]) ? -req_b : req_b;

  assign accept   = (state == muldiv_pkg::IDLE) && req_val;
  assign send     = (state == muldiv_pkg::DONE) && resp_rdy;
  assign req_rdy  = (state == muldiv_pkg::IDLE);
  assign resp_val = (state == muldiv_pkg::DONE);

  // acc is frozen outside CALC, so the result holds in DONE
  assign result = neg ? -acc : acc;

  // ------------------------------------------------------------
  // FSM and counter
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        muldiv_pkg::IDLE: begin
          if (accept) begin
            state <= muldiv_pkg::CALC;
            cnt   <= muldiv_pkg::CNT_TOP;
          end
        end
        muldiv_pkg::CALC: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            state <= muldiv_pkg::DONE;
          end
        end
        muldiv_pkg::DONE: begin
          if (send) begin
            state <= muldiv_pkg::IDLE;
          end
        end
        default: begin
          state <= muldiv_pkg::IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // shift-and-add datapath
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= {{muldiv_pkg::XLEN{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      // product is negative when exactly one signed operand is negative
      neg    <= is_signed && (req_a[muldiv_pkg::XLEN-1] ^ req_b[muldiv_pkg::XLEN-1]);
    end else if (state == muldiv_pkg::CALC) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // result frozen under back-pressure
  a_result_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(result));

  // response presented 33 cycles after the accepting edge
  a_latency: assert property (@(posedge clk) disable iff (reset)
    accept |-> ##33 resp_val);

endmodule

// File: logic/div_ctrl.sv
// divider control
// IDLE/CALC/DONE FSM driving the datapath and the request/response strobes

`timescale 1ns/100ps

module div_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_val,
  input  muldiv_pkg::muldiv_fn_e req_fn,
  input  logic                   resp_rdy,
  output logic                   req_rdy,
  output logic                   resp_val,
  div_ctrl_if.ctrl               ctrl_if
);

  muldiv_pkg::unit_state_e state;

  // request taken this cycle
  logic accept;
  // response taken this cycle
  logic send;

  assign accept = (state == muldiv_pkg::IDLE) && req_val;
  assign send   = (state == muldiv_pkg::DONE) && resp_rdy;

  // only the signed divide works on magnitudes
  assign ctrl_if.is_signed = (req_fn == muldiv_pkg::DIV);

  // ------------------------------------------------------------
  // state register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::IDLE;
    end else begin
      case (state)
        muldiv_pkg::IDLE: begin
          if (accept) begin
            state <= muldiv_pkg::CALC;
          end
        end
        muldiv_pkg::CALC: begin
          // last iteration runs on the cycle the counter reads zero
          if (ctrl_if.cnt_zero) begin
            state <= muldiv_pkg::DONE;
          end
        end
        muldiv_pkg::DONE: begin
          if (send) begin
            state <= muldiv_pkg::IDLE;
          end
        end
        default: begin
          state <= muldiv_pkg::IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // control outputs
  // ------------------------------------------------------------

  always_comb begin
    // everything off unless a state turns it on
    req_rdy            = 1'b0;
    resp_val           = 1'b0;
    ctrl_if.a_en       = 1'b0;
    ctrl_if.b_en       = 1'b0;
    ctrl_if.a_sel_iter = 1'b0;
    ctrl_if.restore    = 1'b0;
    ctrl_if.cnt_load   = 1'b0;
    ctrl_if.sign_en    = 1'b0;
    case (state)
      muldiv_pkg::IDLE: begin
        req_rdy          = 1'b1;
        // load operands, counter and signs on the accepting edge
        ctrl_if.a_en     = accept;
        ctrl_if.b_en     = accept;
        ctrl_if.cnt_load = accept;
        ctrl_if.sign_en  = accept;
      end
      muldiv_pkg::CALC: begin
        ctrl_if.a_en       = 1'b1;
        ctrl_if.a_sel_iter = 1'b1;
        // negative trial difference means the divisor did not fit
        ctrl_if.restore    = ctrl_if.sub_neg;
      end
      muldiv_pkg::DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // a loaded counter reaches zero after exactly 32 iterations
  a_iter_count: assert property (@(posedge clk) disable iff (reset)
    ctrl_if.cnt_load |-> ##32 ctrl_if.cnt_zero);

  // a presented response is held until the consumer takes it
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val);

  // datapath counter rests at zero whenever the FSM is idle
  a_idle_cnt: assert property (@(posedge clk) disable iff (reset)
    (state == muldiv_pkg::IDLE) |-> ctrl_if.cnt_zero);

endmodule

// File: logic/div_dpath.sv
// divider datapath
// restoring shift/subtract on operand magnitudes, sign fixed at the output

`timescale 1ns/100ps

module div_dpath (
  input  logic                          clk,
  input  logic                          reset,
  div_ctrl_if.dpath                     ctrl_if,
  input  logic [muldiv_pkg::XLEN-1:0]   req_a,
  input  logic [muldiv_pkg::XLEN-1:0]   req_b,
  output logic [2*muldiv_pkg::XLEN-1:0] result
);

  // remainder in the high half, quotient bits shift in at the bottom
  logic [2*muldiv_pkg::XLEN-1:0] a_reg;
  // divisor magnitude, lines up under the remainder half
  logic [muldiv_pkg::XLEN-1:0]   b_reg;
  logic [muldiv_pkg::CNT_W-1:0]  cnt;
  logic                          q_neg;
  logic                          r_neg;

  logic [muldiv_pkg::XLEN-1:0]   mag_a;
  logic [muldiv_pkg::XLEN-1:0]   mag_b;
  logic [muldiv_pkg::XLEN:0]     rem_shift;
  logic [muldiv_pkg::XLEN:0]     diff;
  logic [2*muldiv_pkg::XLEN-1:0] a_init;
  logic [2*muldiv_pkg::XLEN-1:0] a_iter;
  logic [muldiv_pkg::XLEN-1:0]   rem;
  logic [muldiv_pkg::XLEN-1:0]   quo;

  // magnitudes only for the signed divide
  assign mag_a = (ctrl_if.is_signed && req_a[muldiv_pkg::XLEN-1]) ? -req_a : req_a;
  assign mag_b = (ctrl_if.is_signed && req_b[muldiv_pkg::XLEN-1]) ? -req_b : req_b;

  assign a_init = {{muldiv_pkg::XLEN{1'b0}}, mag_a};

  // ------------------------------------------------------------
  // trial subtraction
  // ------------------------------------------------------------

  // upper 33 bits of the register shifted left by one
  assign rem_shift = a_reg[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN-1];
  assign diff      = rem_shift - {1'b0, b_reg};

  // borrow out means the divisor did not fit
  assign ctrl_if.sub_neg = diff[muldiv_pkg::XLEN];

  // restore keeps the shifted value with a zero quotient bit
  assign a_iter = ctrl_if.restore ?
                  {a_reg[2*muldiv_pkg::XLEN-2:0], 1'b0} :
                  {diff[muldiv_pkg::XLEN-1:0], a_reg[muldiv_pkg::XLEN-2:0], 1'b1};

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl_if.a_en) begin
      a_reg <= ctrl_if.a_sel_iter ? a_iter : a_init;
    end
    if (ctrl_if.b_en) begin
      b_reg <= mag_b;
    end
    if (ctrl_if.sign_en) begin
      // quotient negative when the signs differ, remainder follows the dividend
      q_neg <= ctrl_if.is_signed && (req_a[muldiv_pkg::XLEN-1] ^ req_b[muldiv_pkg::XLEN-1]);
      r_neg <= ctrl_if.is_signed && req_a[muldiv_pkg::XLEN-1];
    end
  end

  // iteration counter rests at zero between operations
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (ctrl_if.cnt_load) begin
      cnt <= muldiv_pkg::CNT_TOP;
    end else if (!ctrl_if.cnt_zero) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign ctrl_if.cnt_zero = (cnt == '0);

  // ------------------------------------------------------------
  // sign correction
  // ------------------------------------------------------------

  assign rem    = a_reg[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN];
  assign quo    = a_reg[muldiv_pkg::XLEN-1:0];
  assign result = {r_neg ? -rem : rem, q_neg ? -quo : quo};

endmodule

// File: logic/div_ctrl_if.sv
// divider control interface
// enables and selects from the divider FSM, status back from the datapath

`timescale 1ns/100ps

interface div_ctrl_if;

  // driven by the FSM
  logic a_en;
  logic b_en;
  logic a_sel_iter;
  logic restore;
  logic cnt_load;
  logic sign_en;
  logic is_signed;

  // driven by the datapath
  logic sub_neg;
  logic cnt_zero;

  modport ctrl (
    output a_en, b_en, a_sel_iter, restore, cnt_load, sign_en, is_signed,
    input  sub_neg, cnt_zero
  );

  modport dpath (
    input  a_en, b_en, a_sel_iter, restore, cnt_load, sign_en, is_signed,
    output sub_neg, cnt_zero
  );

endinterface

// File: logic/muldiv_pkg.sv
// muldiv shared definitions
// function codes, unit states and datapath sizes for the iterative mul/div unit

package muldiv_pkg;

  // ------------------------------------------------------------
  // widths and iteration count
  // ------------------------------------------------------------

  // operand width of the processor
  localparam int XLEN = 32;

  // one shift step per operand bit
  localparam int ITER_COUNT = 32;

  // counter runs ITER_COUNT-1 down to zero
  localparam int CNT_W = 5;

  // value loaded into the iteration counter on accept
  localparam logic [CNT_W-1:0] CNT_TOP = CNT_W'(ITER_COUNT - 1);

  // ------------------------------------------------------------
  // request function codes
  // ------------------------------------------------------------

  // MUL/MULU go to the multiplier, DIV/DIVU to the divider
  typedef enum logic [1:0] {
    MUL  = 2'd0,
    MULU = 2'd1,
    DIV  = 2'd2,
    DIVU = 2'd3
  } muldiv_fn_e;

  // ------------------------------------------------------------
  // unit FSM states
  // ------------------------------------------------------------

  // shared by the divider control and the multiplier
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } unit_state_e;

endpackage
